// ==== Makefile ====
TOP := tb_rv_core

sim:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "^No errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// ==== compile.f ====
src/rv_core_pkg.sv
src/instr_intake.sv
src/decoder.sv
src/reg_file.sv
src/forward_unit.sv
src/alu.sv
src/data_ram.sv
src/rv_core_top.sv
tests/rv_core_assert.sv
tests/tb_rv_core.sv

// ==== src/alu.sv ====
`timescale 1ns/1ps

module alu import rv_core_pkg::*; (
    input  alu_op_e op_i,
    input  xlen_t   a_i,
    input  xlen_t   b_i,
    output xlen_t   result_o
);

    localparam int SHW = $clog2(XLEN);

    logic [SHW-1:0] shamt;

    assign shamt = b_i[SHW-1:0];                // low 6 bits only

    always_comb begin
        case (op_i)
            ADD:     result_o = a_i + b_i;
            SUB:     result_o = a_i - b_i;
            AND:     result_o = a_i & b_i;
            OR:      result_o = a_i | b_i;
            XOR:     result_o = a_i ^ b_i;
            SLL:     result_o = a_i << shamt;
            SRL:     result_o = a_i >> shamt;
            SRA:     result_o = xlen_t'($signed(a_i) >>> shamt);
            SLT:     result_o = {{(XLEN-1){1'b0}}, $signed(a_i) < $signed(b_i)};
            SLTU:    result_o = {{(XLEN-1){1'b0}}, a_i < b_i};
            PASS_B:  result_o = b_i;                // lui
            default: result_o = '0;
        endcase
    end

endmodule

// ==== src/data_ram.sv ====
`timescale 1ns/1ps

module data_ram import rv_core_pkg::*; (
    input  logic      clk,
    input  dram_idx_t idx_i,
    input  logic      we_i,
    input  xlen_t     wdata_i,
    output xlen_t     rdata_o
);

    xlen_t mem [DRAM_WORDS];

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[idx_i] <= wdata_i;              // full doubleword only
        end
    end

    assign rdata_o = mem[idx_i];                // async read, feeds MEM forwarding

endmodule

// ==== src/decoder.sv ====
`timescale 1ns/1ps

module decoder import rv_core_pkg::*; (
    input  instr_t   instr_i,
    input  logic     valid_i,
    output decoded_t dec_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_idx_t   rd;
    xlen_t      imm_i;
    xlen_t      imm_s;
    xlen_t      imm_u;
    alu_op_e    arith_op;
    logic       reg_ok;
    logic       imm_ok;

    assign opcode = instr_i[6:0];
    assign rd     = instr_i[11:7];
    assign funct3 = instr_i[14:12];
    assign rs1    = instr_i[19:15];
    assign rs2    = instr_i[24:20];
    assign funct7 = instr_i[31:25];

    assign imm_i = {{(XLEN-12){instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{(XLEN-12){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_u = {{(XLEN-32){instr_i[31]}}, instr_i[31:12], 12'b0};

    // mul/div and other funct7 values fall out here
    assign reg_ok = (funct7 == F7_BASE) ||
                    (funct7 == F7_ALT && (funct3 == F3_ADD || funct3 == F3_SR));
    // rv64 shifts carry a 6-bit shamt, funct6 above it
    assign imm_ok = (funct3 == F3_SLL) ? (instr_i[31:26] == 6'b000000) :
                    (funct3 == F3_SR)  ? (instr_i[31:26] == 6'b000000 ||
                                          instr_i[31:26] == 6'b010000) : 1'b1;

    always_comb begin
        case (funct3)
            F3_ADD:  arith_op = (opcode == OP_REG && funct7[5]) ? SUB : ADD;
            F3_SLL:  arith_op = SLL;
            F3_SLT:  arith_op = SLT;
            F3_SLTU: arith_op = SLTU;
            F3_XOR:  arith_op = XOR;
            F3_SR:   arith_op = funct7[5] ? SRA : SRL;
            F3_OR:   arith_op = OR;
            default: arith_op = AND;
        endcase
    end

    always_comb begin
        dec_o = '0;                             // bubble unless recognised
        if (valid_i) begin
            case (opcode)
                OP_REG: if (reg_ok) begin
                    dec_o.rs1    = rs1;
                    dec_o.rs2    = rs2;
                    dec_o.rd     = rd;
                    dec_o.alu_op = arith_op;
                    dec_o.reg_we = (rd != '0);
                end
                OP_IMM: if (imm_ok) begin
                    dec_o.rs1     = rs1;
                    dec_o.rd      = rd;
                    dec_o.imm     = imm_i;
                    dec_o.use_imm = 1'b1;
                    dec_o.alu_op  = arith_op;
                    dec_o.reg_we  = (rd != '0);
                end
                OP_LUI: begin
                    dec_o.rd      = rd;
                    dec_o.imm     = imm_u;
                    dec_o.use_imm = 1'b1;
                    dec_o.alu_op  = PASS_B;
                    dec_o.reg_we  = (rd != '0);
                end
                OP_LOAD: if (funct3 == F3_DWORD) begin
                    dec_o.rs1     = rs1;
                    dec_o.rd      = rd;
                    dec_o.imm     = imm_i;
                    dec_o.use_imm = 1'b1;       // address = rs1 + imm
                    dec_o.is_load = 1'b1;
                    dec_o.reg_we  = (rd != '0);
                end
                OP_STORE: if (funct3 == F3_DWORD) begin
                    dec_o.rs1      = rs1;
                    dec_o.rs2      = rs2;
                    dec_o.imm      = imm_s;
                    dec_o.use_imm  = 1'b1;
                    dec_o.is_store = 1'b1;
                end
                OP_SYSTEM: dec_o.is_ebreak = (instr_i == EBREAK_WORD);
                default: ;
            endcase
        end
    end

endmodule

// ==== src/forward_unit.sv ====
`timescale 1ns/1ps

module forward_unit import rv_core_pkg::*; (
    input  reg_idx_t rs1_i,
    input  reg_idx_t rs2_i,
    input  reg_idx_t ex_rd_i,
    input  logic     ex_reg_we_i,
    input  logic     ex_is_load_i,
    input  ex_mem_t  mem_i,
    input  mem_wb_t  wb_i,
    output src_sel_e sel_a_o,
    output src_sel_e sel_b_o,
    output logic     stall_o
);

    logic ex_hit;

    // youngest producer wins, x0 never forwarded
    function automatic src_sel_e pick(reg_idx_t rs, ex_mem_t m, mem_wb_t w);
        src_sel_e sel;
        sel = REGFILE;
        if (rs != '0) begin
            if (m.reg_we && m.rd == rs) begin
                sel = FROM_MEM;
            end else if (w.reg_we && w.rd == rs) begin
                sel = FROM_WB;
            end
        end
        return sel;
    endfunction

    assign sel_a_o = pick(rs1_i, mem_i, wb_i);
    assign sel_b_o = pick(rs2_i, mem_i, wb_i);

    assign ex_hit = (ex_rd_i == rs1_i) || (ex_rd_i == rs2_i);

    // load data only exists once the load sits in MEM
    assign stall_o = ex_is_load_i && ex_reg_we_i && (ex_rd_i != '0) && ex_hit;

endmodule

// ==== src/instr_intake.sv ====
`timescale 1ns/1ps

module instr_intake import rv_core_pkg::*; (
    input  logic   clk,
    input  logic   rst_n_i,
    input  logic   req_i,
    input  instr_t instr_i,
    output logic   ack_o,
    input  logic   halt_i,
    input  logic   advance_i,
    output logic   slot_valid_o,
    output instr_t slot_instr_o
);

    intake_state_e state_q;
    instr_t        slot_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE:    if (req_i && !halt_i) state_q <= FULL;
                FULL:    if (advance_i) state_q <= ACKED;   // decode took the slot
                ACKED:   if (!req_i) state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE && req_i) begin
            slot_q <= instr_i;                  // req keeps instr stable
        end
    end

    assign slot_valid_o = (state_q == FULL);
    assign slot_instr_o = slot_q;

    // ack goes up in the cycle decode hands the slot on, then holds until req drops
    assign ack_o = (state_q == ACKED) || (state_q == FULL && advance_i);

endmodule

// ==== src/reg_file.sv ====
`timescale 1ns/1ps

module reg_file import rv_core_pkg::*; (
    input  logic     clk,
    input  reg_idx_t ra_i,
    input  reg_idx_t rb_i,
    output xlen_t    rdata_a_o,
    output xlen_t    rdata_b_o,
    input  logic     we_i,
    input  reg_idx_t rw_i,
    input  xlen_t    wdata_i
);

    xlen_t regs [1:31];                         // x0 has no storage

    always_ff @(posedge clk) begin
        if (we_i && rw_i != '0) begin
            regs[rw_i] <= wdata_i;
        end
    end

    // old value on a same-cycle write, WB forwarding covers that case
    assign rdata_a_o = (ra_i == '0) ? '0 : regs[ra_i];
    assign rdata_b_o = (rb_i == '0) ? '0 : regs[rb_i];

endmodule

// ==== src/rv_core_pkg.sv ====
package rv_core_pkg;

    localparam int XLEN = 64;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [31:0]     instr_t;
    typedef logic [4:0]      reg_idx_t;

    localparam int DRAM_WORDS   = 32;
    localparam int DRAM_IDX_LSB = 3;                // doubleword aligned

    typedef logic [$clog2(DRAM_WORDS)-1:0] dram_idx_t;

    // major opcodes of the kept subset
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    localparam logic [2:0] F3_ADD   = 3'b000;
    localparam logic [2:0] F3_SLL   = 3'b001;
    localparam logic [2:0] F3_SLT   = 3'b010;
    localparam logic [2:0] F3_SLTU  = 3'b011;
    localparam logic [2:0] F3_XOR   = 3'b100;
    localparam logic [2:0] F3_SR    = 3'b101;   // srl and sra
    localparam logic [2:0] F3_OR    = 3'b110;
    localparam logic [2:0] F3_AND   = 3'b111;
    localparam logic [2:0] F3_DWORD = 3'b011;   // ld / sd width

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000; // sub, sra

    localparam instr_t EBREAK_WORD = 32'h0010_0073;

    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU, PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {REGFILE, FROM_MEM, FROM_WB} src_sel_e;

    typedef enum logic [1:0] {IDLE, FULL, ACKED} intake_state_e;

    typedef struct packed {
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        xlen_t    imm;
        logic     use_imm;
        alu_op_e  alu_op;
        logic     is_load;
        logic     is_store;
        logic     reg_we;
        logic     is_ebreak;
    } decoded_t;

    typedef struct packed {
        reg_idx_t rd;
        xlen_t    result;
        xlen_t    store_data;
        logic     is_load;
        logic     is_store;
        logic     reg_we;
        logic     is_ebreak;
    } ex_mem_t;

    typedef struct packed {
        reg_idx_t rd;
        xlen_t    data;
        logic     reg_we;
        logic     is_ebreak;
    } mem_wb_t;

    typedef struct packed {
        reg_idx_t rd;
        xlen_t    data;
    } retire_t;

endpackage

// ==== src/rv_core_top.sv ====
`timescale 1ns/1ps

module rv_core_top import rv_core_pkg::*; (
    input  logic    clk,
    input  logic    rst_n_i,
    input  logic    instr_req_i,
    input  instr_t  instr_i,
    output logic    instr_ack_o,
    output logic    retire_valid_o,
    output retire_t retire_o,
    output logic    halt_o
);

    logic     slot_valid;
    instr_t   slot_instr;
    logic     stall;
    decoded_t id_dec;
    xlen_t    rf_a;
    xlen_t    rf_b;
    src_sel_e id_sel_a;
    src_sel_e id_sel_b;
    xlen_t    id_a;
    xlen_t    id_b;

    decoded_t ex_dec;                           // ID/EX control
    xlen_t    ex_a_q;
    xlen_t    ex_b_q;
    src_sel_e ex_sel_a;
    src_sel_e ex_sel_b;
    xlen_t    ex_a;
    xlen_t    ex_b;
    xlen_t    alu_result;
    ex_mem_t  ex_out;

    ex_mem_t  mem_q;
    xlen_t    ram_rdata;
    xlen_t    mem_data;
    mem_wb_t  wb_q;
    logic     halt_q;

    function automatic xlen_t fwd_mux(src_sel_e sel, xlen_t own, xlen_t mem_v, xlen_t wb_v);
        xlen_t val;
        case (sel)
            FROM_MEM: val = mem_v;
            FROM_WB:  val = wb_v;
            default:  val = own;
        endcase
        return val;
    endfunction

    instr_intake u_intake (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .req_i        (instr_req_i),
        .instr_i      (instr_i),
        .ack_o        (instr_ack_o),
        .halt_i       (halt_o),
        .advance_i    (!stall),
        .slot_valid_o (slot_valid),
        .slot_instr_o (slot_instr)
    );

    decoder u_dec (
        .instr_i (slot_instr),
        .valid_i (slot_valid),
        .dec_o   (id_dec)
    );

    reg_file u_rf (
        .clk       (clk),
        .ra_i      (id_dec.rs1),
        .rb_i      (id_dec.rs2),
        .rdata_a_o (rf_a),
        .rdata_b_o (rf_b),
        .we_i      (wb_q.reg_we),
        .rw_i      (wb_q.rd),
        .wdata_i   (wb_q.data)
    );

    forward_unit u_fwd_id (
        .rs1_i        (id_dec.rs1),
        .rs2_i        (id_dec.rs2),
        .ex_rd_i      (ex_dec.rd),
        .ex_reg_we_i  (ex_dec.reg_we),
        .ex_is_load_i (ex_dec.is_load),
        .mem_i        (mem_q),
        .wb_i         (wb_q),
        .sel_a_o      (id_sel_a),
        .sel_b_o      (id_sel_b),
        .stall_o      (stall)
    );

    assign mem_data = mem_q.is_load ? ram_rdata : mem_q.result;
    assign id_a     = fwd_mux(id_sel_a, rf_a, mem_data, wb_q.data);
    assign id_b     = fwd_mux(id_sel_b, rf_b, mem_data, wb_q.data);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ex_dec <= '0;
        end else if (stall) begin
            ex_dec <= '0;                       // load-use bubble, ID holds
        end else begin
            ex_dec <= id_dec;                   // empty slot decodes to a bubble
        end
    end

    always_ff @(posedge clk) begin
        ex_a_q <= id_a;
        ex_b_q <= id_b;
    end

    // the producer right ahead was still in EX at decode time, pick it up from MEM now
    forward_unit u_fwd_ex (
        .rs1_i        (ex_dec.rs1),
        .rs2_i        (ex_dec.rs2),
        .ex_rd_i      ('0),
        .ex_reg_we_i  (1'b0),
        .ex_is_load_i (1'b0),
        .mem_i        (mem_q),
        .wb_i         (wb_q),
        .sel_a_o      (ex_sel_a),
        .sel_b_o      (ex_sel_b),
        .stall_o      ()
    );

    assign ex_a = fwd_mux(ex_sel_a, ex_a_q, mem_data, wb_q.data);
    assign ex_b = fwd_mux(ex_sel_b, ex_b_q, mem_data, wb_q.data);

    alu u_alu (
        .op_i     (ex_dec.alu_op),
        .a_i      (ex_a),
        .b_i      (ex_dec.use_imm ? ex_dec.imm : ex_b),
        .result_o (alu_result)
    );

    always_comb begin
        ex_out.rd         = ex_dec.rd;
        ex_out.result     = alu_result;         // also the ld/sd address
        ex_out.store_data = ex_b;
        ex_out.is_load    = ex_dec.is_load;
        ex_out.is_store   = ex_dec.is_store;
        ex_out.reg_we     = ex_dec.reg_we;
        ex_out.is_ebreak  = ex_dec.is_ebreak;
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            mem_q <= '0;
        end else begin
            mem_q <= ex_out;
        end
    end

    data_ram u_dram (
        .clk     (clk),
        .idx_i   (mem_q.result[DRAM_IDX_LSB +: $bits(dram_idx_t)]),
        .we_i    (mem_q.is_store),
        .wdata_i (mem_q.store_data),
        .rdata_o (ram_rdata)
    );

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wb_q <= '0;
        end else begin
            wb_q.rd        <= mem_q.rd;
            wb_q.data      <= mem_data;
            wb_q.reg_we    <= mem_q.reg_we;
            wb_q.is_ebreak <= mem_q.is_ebreak;
        end
    end

    // trace port, one register behind WB
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            retire_valid_o <= 1'b0;
        end else begin
            retire_valid_o <= wb_q.reg_we;      // x0 writes never set reg_we
        end
    end

    always_ff @(posedge clk) begin
        retire_o.rd   <= wb_q.rd;
        retire_o.data <= wb_q.data;
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            halt_q <= 1'b0;
        end else if (wb_q.is_ebreak) begin
            halt_q <= 1'b1;                     // sticky until reset
        end
    end

    assign halt_o = halt_q || wb_q.is_ebreak;

endmodule

// ==== tests/rv_core_assert.sv ====
`timescale 1ns/1ps

module rv_core_assert import rv_core_pkg::*; (
    input logic    clk,
    input logic    rst_n_i,
    input logic    instr_req_i,
    input logic    instr_ack_o,
    input logic    retire_valid_o,
    input retire_t retire_o,
    input logic    halt_o
);

    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(instr_ack_o) |-> instr_req_i)
        else $error("ack rose while req was low");

    // ack may only drop once req has gone
    ack_falls_after_req: assert property (@(posedge clk) disable iff (!rst_n_i)
        $fell(instr_ack_o) |-> !$past(instr_req_i))
        else $error("ack fell while req was still high");

    retire_not_x0: assert property (@(posedge clk) disable iff (!rst_n_i)
        retire_valid_o |-> retire_o.rd != '0)
        else $error("retire port carried register x0");

    quiet_after_reset: assert property (@(posedge clk)
        $rose(rst_n_i) |-> !retire_valid_o && !instr_ack_o && !halt_o)
        else $error("outputs not low in the first cycle after reset");

endmodule

bind rv_core_top rv_core_assert u_assert (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .instr_req_i    (instr_req_i),
    .instr_ack_o    (instr_ack_o),
    .retire_valid_o (retire_valid_o),
    .retire_o       (retire_o),
    .halt_o         (halt_o)
);

// ==== tests/tb_rv_core.sv ====
`timescale 1ns/1ps

module tb_rv_core import rv_core_pkg::*; ();

    localparam int ACK_LIMIT  = 20;
    localparam int HALT_LIMIT = 20;
    localparam int RETIRE_LAT = 4;              // ack cycle to retire cycle

    logic    clk;
    logic    rst_n_i;
    logic    instr_req_i;
    instr_t  instr_i;
    logic    instr_ack_o;
    logic    retire_valid_o;
    retire_t retire_o;
    logic    halt_o;

    string    name_q[$];                        // one entry per table row
    instr_t   word_q[$];
    reg_idx_t rd_q[$];
    xlen_t    data_q[$];
    int       pending_q[$];                     // rows still expected on retire
    int       ack_cycle_q[$];                   // cycle each row saw its ack
    int       cycle_cnt;
    logic [31:0] rng;

    rv_core_top dut0 (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .instr_req_i    (instr_req_i),
        .instr_i        (instr_i),
        .instr_ack_o    (instr_ack_o),
        .retire_valid_o (retire_valid_o),
        .retire_o       (retire_o),
        .halt_o         (halt_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic instr_t r_type(input logic [6:0] f7, input logic [2:0] f3,
                                      input int rd, input int rs1, input int rs2);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OP_REG};
    endfunction

    function automatic instr_t i_type(input logic [6:0] op, input logic [2:0] f3,
                                      input int rd, input int rs1, input int imm);
        return {12'(imm), 5'(rs1), f3, 5'(rd), op};
    endfunction

    function automatic instr_t s_type(input int rs2, input int rs1, input int imm);
        logic [11:0] im;
        im = 12'(imm);
        return {im[11:5], 5'(rs2), 5'(rs1), F3_DWORD, im[4:0], OP_STORE};
    endfunction

    function automatic instr_t u_type(input int rd, input int imm20);
        return {20'(imm20), 5'(rd), OP_LUI};
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input xlen_t expected, input xlen_t actual);
        if (expected !== actual) begin
            fail_run($sformatf("mismatch %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic add_row(input string name, input instr_t word, input bit retires,
                           input int rd, input xlen_t data);
        name_q.push_back(name);
        word_q.push_back(word);
        rd_q.push_back(5'(rd));
        data_q.push_back(data);
        if (retires) begin
            pending_q.push_back(name_q.size() - 1);
        end
    endtask

    // expected values follow rv64 semantics in program order
    task automatic build_table();
        add_row("lui_pos",     u_type(1, 'h12345), 1'b1, 1, 64'h0000_0000_1234_5000);
        add_row("lui_neg",     u_type(2, 'h80000), 1'b1, 2, 64'hffff_ffff_8000_0000);
        add_row("addi_neg",    i_type(OP_IMM, F3_ADD, 3, 1, -1), 1'b1, 3, 64'h1234_4fff);
        add_row("addi_min",    i_type(OP_IMM, F3_ADD, 4, 0, -2048), 1'b1, 4,
                64'hffff_ffff_ffff_f800);
        add_row("andi_neg",    i_type(OP_IMM, F3_AND, 5, 3, -16), 1'b1, 5, 64'h1234_4ff0);
        add_row("ori",         i_type(OP_IMM, F3_OR, 6, 4, 'h123), 1'b1, 6,
                64'hffff_ffff_ffff_f923);
        add_row("xori_not",    i_type(OP_IMM, F3_XOR, 7, 1, -1), 1'b1, 7,
                64'hffff_ffff_edcb_afff);
        add_row("slli_63",     i_type(OP_IMM, F3_SLL, 8, 3, 63), 1'b1, 8,
                64'h8000_0000_0000_0000);
        add_row("srli_63",     i_type(OP_IMM, F3_SR, 9, 8, 63), 1'b1, 9, 64'h1);
        add_row("srai_63",     i_type(OP_IMM, F3_SR, 10, 8, 'h43f), 1'b1, 10, '1);
        add_row("srai_4",      i_type(OP_IMM, F3_SR, 11, 2, 'h404), 1'b1, 11,
                64'hffff_ffff_f800_0000);
        add_row("slti_true",   i_type(OP_IMM, F3_SLT, 12, 4, -1), 1'b1, 12, 64'h1);
        add_row("sltiu_true",  i_type(OP_IMM, F3_SLTU, 13, 4, -1), 1'b1, 13, 64'h1);
        add_row("slti_false",  i_type(OP_IMM, F3_SLT, 14, 1, -1), 1'b1, 14, 64'h0);
        add_row("add",         r_type(F7_BASE, F3_ADD, 15, 1, 4), 1'b1, 15, 64'h1234_4800);
        add_row("sub",         r_type(F7_ALT, F3_ADD, 16, 4, 1), 1'b1, 16,
                64'hffff_ffff_edcb_a800);
        add_row("and",         r_type(F7_BASE, F3_AND, 17, 6, 7), 1'b1, 17,
                64'hffff_ffff_edcb_a923);
        add_row("or",          r_type(F7_BASE, F3_OR, 18, 1, 9), 1'b1, 18, 64'h1234_5001);
        add_row("xor",         r_type(F7_BASE, F3_XOR, 19, 6, 4), 1'b1, 19, 64'h123);
        add_row("sll_63",      r_type(F7_BASE, F3_SLL, 20, 9, 10), 1'b1, 20,
                64'h8000_0000_0000_0000);
        add_row("srl_1",       r_type(F7_BASE, F3_SR, 21, 10, 9), 1'b1, 21,
                64'h7fff_ffff_ffff_ffff);
        add_row("sra_1",       r_type(F7_ALT, F3_SR, 22, 2, 9), 1'b1, 22,
                64'hffff_ffff_c000_0000);
        add_row("slt_min",     r_type(F7_BASE, F3_SLT, 23, 20, 9), 1'b1, 23, 64'h1);
        add_row("sltu_min",    r_type(F7_BASE, F3_SLTU, 24, 20, 9), 1'b1, 24, 64'h0);
        add_row("slt_max",     r_type(F7_BASE, F3_SLT, 25, 21, 20), 1'b1, 25, 64'h0);
        add_row("sltu_ones",   r_type(F7_BASE, F3_SLTU, 26, 9, 10), 1'b1, 26, 64'h1);
        add_row("fwd_base",    i_type(OP_IMM, F3_ADD, 27, 0, 5), 1'b1, 27, 64'h5);
        add_row("fwd_mem",     r_type(F7_BASE, F3_ADD, 28, 27, 27), 1'b1, 28, 64'ha);
        add_row("fwd_mem_wb",  r_type(F7_BASE, F3_ADD, 29, 28, 27), 1'b1, 29, 64'hf);
        add_row("fwd_sub",     r_type(F7_ALT, F3_ADD, 30, 29, 28), 1'b1, 30, 64'h5);
        add_row("fwd_imm",     i_type(OP_IMM, F3_ADD, 31, 30, 1), 1'b1, 31, 64'h6);
        add_row("ram_base",    i_type(OP_IMM, F3_ADD, 1, 0, 64), 1'b1, 1, 64'h40);
        add_row("sd_min",      s_type(20, 1, 8), 1'b0, 0, 64'h0);
        add_row("ld_min",      i_type(OP_LOAD, F3_DWORD, 2, 1, 8), 1'b1, 2,
                64'h8000_0000_0000_0000);
        add_row("ld_use",      i_type(OP_IMM, F3_ADD, 3, 2, 1), 1'b1, 3,
                64'h8000_0000_0000_0001);
        add_row("sd_fwd",      s_type(3, 1, -8), 1'b0, 0, 64'h0);
        add_row("ld_back",     i_type(OP_LOAD, F3_DWORD, 4, 1, -8), 1'b1, 4,
                64'h8000_0000_0000_0001);
        add_row("ld_use_both", r_type(F7_BASE, F3_ADD, 5, 4, 4), 1'b1, 5, 64'h2);
        add_row("x0_addi",     i_type(OP_IMM, F3_ADD, 0, 1, 7), 1'b0, 0, 64'h0);
        add_row("x0_lui",      u_type(0, 'habcde), 1'b0, 0, 64'h0);
        add_row("x0_read",     r_type(F7_BASE, F3_ADD, 6, 0, 1), 1'b1, 6, 64'h40);
        add_row("x0_or",       r_type(F7_BASE, F3_OR, 7, 0, 0), 1'b1, 7, 64'h0);
        add_row("mul_bubble",  r_type(7'b0000001, F3_ADD, 8, 1, 1), 1'b0, 0, 64'h0);
        add_row("ebreak",      EBREAK_WORD, 1'b0, 0, 64'h0);
    endtask

    // one four-phase transfer with a random idle gap in front
    task automatic send_row(input int i);
        int n;
        int gap;
        rng = xorshift32(rng);
        gap = int'(rng[1:0]);
        repeat (gap) @(posedge clk);
        @(posedge clk);
        instr_i     <= word_q[i];
        instr_req_i <= 1'b1;
        n = 0;
        @(negedge clk);
        while (!instr_ack_o && n < ACK_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!instr_ack_o) fail_run({"no ack for instruction of ", name_q[i]});
        ack_cycle_q.push_back(cycle_cnt);
        @(posedge clk);
        instr_req_i <= 1'b0;
        n = 0;
        @(negedge clk);
        while (instr_ack_o && n < ACK_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (instr_ack_o) fail_run({"ack stayed high after req dropped for ", name_q[i]});
    endtask

    always @(negedge clk) begin
        int k;
        if (rst_n_i && retire_valid_o) begin
            if (pending_q.size() == 0) begin
                fail_run($sformatf("unexpected retire to register x%0d", retire_o.rd));
            end else begin
                k = pending_q.pop_front();
                check_value({name_q[k], " rd"}, xlen_t'(rd_q[k]), xlen_t'(retire_o.rd));
                check_value(name_q[k], data_q[k], retire_o.data);
                check_value({name_q[k], " latency"}, xlen_t'(RETIRE_LAT),
                            xlen_t'(cycle_cnt - ack_cycle_q[k]));
            end
        end
    end

    initial begin
        int i;
        int n;
        rng         = 32'h0ca00c7f;
        cycle_cnt   = 0;
        rst_n_i     = 1'b0;
        instr_req_i = 1'b0;
        instr_i     = '0;
        build_table();
        fork
            begin
                repeat (10 + 40 * name_q.size()) @(posedge clk);
                fail_run("watchdog expired before the test sequence finished");
            end
        join_none
        repeat (10) @(posedge clk);
        rst_n_i <= 1'b1;
        for (i = 0; i < name_q.size(); i++) begin
            send_row(i);
        end
        n = 0;
        @(negedge clk);
        while (!halt_o && n < HALT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!halt_o) fail_run("halt_o did not rise after ebreak");
        // halted core must leave this request hanging
        @(posedge clk);
        instr_i     <= i_type(OP_IMM, F3_ADD, 9, 0, 1);
        instr_req_i <= 1'b1;
        repeat (20) begin
            @(negedge clk);
            if (instr_ack_o) fail_run("a request was acked after halt");
        end
        @(posedge clk);
        instr_req_i <= 1'b0;
        @(negedge clk);
        if (pending_q.size() != 0) begin
            fail_run($sformatf("%0d expected retires never arrived", pending_q.size()));
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule
